// ==== verilog/bch_pkg.sv ====
`default_nettype none

package bch_pkg;

	localparam int bch_m = 4;	// field width, GF(2^4).
	localparam int bch_n = 15;	// code length.
	localparam int bch_k = 5;	// message length.
	localparam int bch_t = 3;	// correctable errors.
	localparam int bch_lat = 38;	// accepting start edge to done.

	typedef logic [bch_m-1:0] gf_t;		// one field element.
	typedef logic [bch_n-1:0] word_t;	// bit i is coefficient of x^i.

	typedef struct packed {
		gf_t s1;
		gf_t s2;	// s1 squared.
		gf_t s3;
		gf_t s4;	// s2 squared.
		gf_t s5;
		gf_t s6;	// s3 squared.
	} syn_t;

	typedef struct packed {
		gf_t sigma0;	// constant term, always 1.
		gf_t sigma1;
		gf_t sigma2;
		gf_t sigma3;
		logic [1:0] deg;	// locator degree, saturates at t.
	} sigma_t;

	// alpha^k in polynomial basis.
	localparam gf_t gf_exp [bch_n] = '{
		4'h1, 4'h2, 4'h4, 4'h8, 4'h3, 4'h6, 4'hc, 4'hb,
		4'h5, 4'ha, 4'h7, 4'he, 4'hf, 4'hd, 4'h9
	};

	// entry 0 has no inverse, left as 0.
	localparam gf_t gf_inv_tab [2**bch_m] = '{
		4'h0, 4'h1, 4'h9, 4'he, 4'hd, 4'hb, 4'h7, 4'h6,
		4'hf, 4'h2, 4'hc, 4'h5, 4'ha, 4'h4, 4'h3, 4'h8
	};

	function automatic gf_t gf_mul(gf_t a, gf_t b);
		logic [2*bch_m-2:0] p;	// raw product, degree up to 6.
		p = '0;
		for (int i = 0; i < bch_m; i++) begin
			if (b[i])
				p ^= (2*bch_m-1)'(a) << i;	// shift and add.
		end
		for (int i = 2*bch_m-2; i >= bch_m; i--) begin
			if (p[i])
				p ^= (2*bch_m-1)'(5'b10011) << (i - bch_m);	// fold by x^4+x+1.
		end
		return p[bch_m-1:0];
	endfunction

	function automatic gf_t gf_inv(gf_t a);
		return gf_inv_tab[a];	// table lookup.
	endfunction

endpackage

`default_nettype wire

// ==== verilog/bch_syndrome.sv ====
`timescale 1ns/10ps
`default_nettype none

module bch_syndrome (
	input wire clk,
	input wire rst_n,
	input wire syn_start,
	input wire bch_pkg::word_t word_in,
	output bch_pkg::syn_t syn,
	output bch_pkg::word_t word_held
);

	bch_pkg::word_t word_q;	// received word, kept for the search.
	bch_pkg::gf_t s1_q;	// r(alpha).
	bch_pkg::gf_t s3_q;	// r(alpha^3).
	bch_pkg::gf_t s5_q;	// r(alpha^5).
	bch_pkg::gf_t s2;
	logic [3:0] idx;	// bit under test, msb first.
	logic run;
	logic bit_in;

	assign bit_in = word_q[idx];
	assign word_held = word_q;

	// binary code, so even syndromes are squares.
	assign s2 = bch_pkg::gf_mul(s1_q, s1_q);

	assign syn = '{
		s1: s1_q,
		s2: s2,
		s3: s3_q,
		s4: bch_pkg::gf_mul(s2, s2),
		s5: s5_q,
		s6: bch_pkg::gf_mul(s3_q, s3_q)
	};

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			run <= 1'b0;
			idx <= '0;
		end else if (syn_start) begin
			run <= 1'b1;
			idx <= 4'(bch_pkg::bch_n - 1);	// start at x^14.
		end else if (run) begin
			if (idx != '0)
				idx <= idx - 4'd1;
			else
				run <= 1'b0;	// last bit taken.
		end
	end

	// horner step: s = s * alpha^j + r_i.
	always_ff @(posedge clk) begin
		if (syn_start) begin
			word_q <= word_in;
			s1_q <= '0;
			s3_q <= '0;
			s5_q <= '0;
		end else if (run) begin
			s1_q <= bch_pkg::gf_mul(s1_q, bch_pkg::gf_exp[1]) ^ bch_pkg::gf_t'(bit_in);
			s3_q <= bch_pkg::gf_mul(s3_q, bch_pkg::gf_exp[3]) ^ bch_pkg::gf_t'(bit_in);
			s5_q <= bch_pkg::gf_mul(s5_q, bch_pkg::gf_exp[5]) ^ bch_pkg::gf_t'(bit_in);
		end
	end

endmodule

`default_nettype wire

// ==== verilog/bch_locator.sv ====
`timescale 1ns/10ps
`default_nettype none

// serial berlekamp-massey with inversion, binary form.
// pass r: d_r = sum sigma_i * S(2r-1-i), then
// sigma += (d_r / d_p) * beta and beta moves up by x^2.
module bch_locator (
	input wire clk,
	input wire rst_n,
	input wire loc_start,
	input wire bch_pkg::syn_t syn,
	output bch_pkg::sigma_t sigma
);

	bch_pkg::gf_t [bch_pkg::bch_t:0] sig;	// locator, index is power of x.
	bch_pkg::gf_t [bch_pkg::bch_t:0] beta;	// correction poly, already shifted.
	bch_pkg::gf_t [2*bch_pkg::bch_t:1] s;	// syndromes by index.
	bch_pkg::gf_t d_p;	// previous nonzero discrepancy.
	bch_pkg::gf_t d_r;	// discrepancy of this pass.
	bch_pkg::gf_t disc;
	bch_pkg::gf_t coef;	// d_r / d_p.
	logic [2:0] len;	// locator length, may pass t.
	logic [2:0] step;	// two steps per pass.
	logic [2:0] r;	// pass number from 1.
	logic run;
	logic bsel;
	logic s1_nz;

	assign s = {syn.s6, syn.s5, syn.s4, syn.s3, syn.s2, syn.s1};
	assign s1_nz = (syn.s1 != '0);
	assign r = {1'b0, step[2:1]} + 3'd1;

	// inner product of sigma with the syndrome window.
	always_comb begin : disc_sum
		disc = '0;
		for (int i = 0; i <= bch_pkg::bch_t; i++) begin
			if (2*int'(r) - 1 - i >= 1)
				disc ^= bch_pkg::gf_mul(sig[i], s[2*int'(r) - 1 - i]);
		end
	end

	assign coef = bch_pkg::gf_mul(d_r, bch_pkg::gf_inv(d_p));

	// length change allowed when 2L <= 2r-2.
	assign bsel = (d_r != '0) && (len <= r - 3'd1);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			run <= 1'b0;
			step <= '0;
		end else if (loc_start) begin
			run <= 1'b1;
			step <= '0;
		end else if (run) begin
			step <= step + 3'd1;
			run <= (step != 3'(2*bch_pkg::bch_t - 1));	// six steps in all.
		end
	end

	always_ff @(posedge clk) begin
		if (loc_start) begin
			// sigma = 1 + S1 x, first pass folded into the load.
			sig <= '0;
			sig[0] <= bch_pkg::gf_t'(1);
			sig[1] <= syn.s1;
			beta <= '0;
			beta[s1_nz ? 2 : 3] <= bch_pkg::gf_t'(1);	// x^2 or x^3.
			d_p <= s1_nz ? syn.s1 : bch_pkg::gf_t'(1);
			len <= {2'b00, s1_nz};
		end else if (run && !step[0]) begin
			d_r <= disc;	// first cycle of a pass.
		end else if (run && step[2:1] != 2'd0) begin
			// first pass only confirms the loaded step.
			for (int i = 0; i <= bch_pkg::bch_t; i++)
				sig[i] <= sig[i] ^ bch_pkg::gf_mul(coef, beta[i]);
			beta <= (bsel ? sig : beta) << (2*bch_pkg::bch_m);	// times x^2.
			if (bsel) begin
				d_p <= d_r;
				len <= 3'(2*int'(r) - 1) - len;
			end
		end
	end

	always_comb begin
		sigma.sigma0 = sig[0];
		sigma.sigma1 = sig[1];
		sigma.sigma2 = sig[2];
		sigma.sigma3 = sig[3];
		sigma.deg = (len > 3'(bch_pkg::bch_t)) ? 2'(bch_pkg::bch_t) : len[1:0];	// saturate.
	end

endmodule

`default_nettype wire

// ==== verilog/bch_chien.sv ====
`timescale 1ns/10ps
`default_nettype none

module bch_chien (
	input wire clk,
	input wire rst_n,
	input wire chien_start,
	input wire bch_pkg::sigma_t sigma,
	input wire bch_pkg::word_t word_held,
	output bch_pkg::word_t word_out,
	output logic [1:0] err_count,
	output logic fail
);

	bch_pkg::gf_t [bch_pkg::bch_t:0] coef;	// sigma as an array.
	bch_pkg::gf_t [bch_pkg::bch_t:0] term;	// sigma_k * alpha^(-i k).
	bch_pkg::gf_t [bch_pkg::bch_t:0] cur;
	bch_pkg::gf_t eval;	// sigma(alpha^-i).
	bch_pkg::word_t fix;	// word with flips so far.
	bch_pkg::word_t flip;
	logic [3:0] pos;
	logic [3:0] pos_cur;
	logic [1:0] roots;
	logic run;
	logic last;	// decision cycle.
	logic hit;
	logic mism;

	assign coef = {sigma.sigma3, sigma.sigma2, sigma.sigma1, sigma.sigma0};
	assign pos_cur = chien_start ? 4'(bch_pkg::bch_n - 1) : pos;

	// alpha^-14k equals alpha^k, so the load already tests position 14.
	always_comb begin : eval_sum
		eval = '0;
		for (int k = 0; k <= bch_pkg::bch_t; k++) begin
			cur[k] = chien_start ? bch_pkg::gf_mul(coef[k], bch_pkg::gf_exp[k]) : term[k];
			eval ^= cur[k];
		end
	end

	assign hit = (eval == '0);
	assign flip = hit ? (bch_pkg::word_t'(1) << pos_cur) : '0;
	assign mism = (roots != sigma.deg);	// root count must match degree.

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			run <= 1'b0;
			pos <= '0;
			last <= 1'b0;
			err_count <= '0;
			fail <= 1'b0;
		end else begin
			last <= run && (pos == '0);
			if (chien_start) begin
				run <= 1'b1;
				pos <= pos_cur - 4'd1;
			end else if (run) begin
				if (pos != '0)
					pos <= pos - 4'd1;
				else
					run <= 1'b0;	// position 0 done.
			end
			if (last) begin
				fail <= mism;
				err_count <= mism ? 2'd0 : roots;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (chien_start || run) begin
			// step to the next lower position.
			for (int k = 0; k <= bch_pkg::bch_t; k++)
				term[k] <= bch_pkg::gf_mul(cur[k], bch_pkg::gf_exp[k]);
			fix <= (chien_start ? word_held : fix) ^ flip;
			roots <= (chien_start ? 2'd0 : roots) + 2'(hit);
		end
		if (last)
			word_out <= mism ? word_held : fix;	// uncorrected on fail.
	end

endmodule

`default_nettype wire

// ==== verilog/bch_sequencer.sv ====
`timescale 1ns/10ps
`default_nettype none

module bch_sequencer (
	input wire clk,
	input wire rst_n,
	input wire start,
	output logic busy,
	output logic syn_start,
	output logic loc_start,
	output logic chien_start,
	output logic done
);

	typedef enum logic [2:0] {
		ph_idle,
		ph_syn,	// syndrome accumulation.
		ph_loc,	// key equation.
		ph_search,	// chien search.
		ph_finish	// fail decision.
	} phase_t;

	phase_t phase;
	logic [5:0] cnt;	// cycles since the accepting edge.

	assign busy = (phase != ph_idle);
	assign syn_start = start && (phase == ph_idle);	// start ignored while busy.

	// sampled at edge 16, after the last horner step.
	assign loc_start = (phase == ph_syn) && (cnt == 6'(bch_pkg::bch_n));

	// sampled at edge 23, one edge after the final sigma update.
	assign chien_start = (phase == ph_loc) &&
		(cnt == 6'(bch_pkg::bch_n + 2*bch_pkg::bch_t + 1));

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			phase <= ph_idle;
			cnt <= '0;
			done <= 1'b0;
		end else begin
			done <= (phase == ph_finish);	// one cycle pulse at bch_lat.
			case (phase)
				ph_idle: begin
					cnt <= '0;
					if (start)
						phase <= ph_syn;
				end
				ph_syn: begin
					cnt <= cnt + 6'd1;
					if (loc_start)
						phase <= ph_loc;
				end
				ph_loc: begin
					cnt <= cnt + 6'd1;
					if (chien_start)
						phase <= ph_search;
				end
				ph_search: begin
					cnt <= cnt + 6'd1;
					if (cnt == 6'(bch_pkg::bch_lat - 2))
						phase <= ph_finish;
				end
				default: begin
					cnt <= '0;
					phase <= ph_idle;	// back to idle with done.
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== verilog/bch_decoder.sv ====
`timescale 1ns/10ps
`default_nettype none

module bch_decoder (
	input wire clk,
	input wire rst_n,
	input wire start,
	input wire bch_pkg::word_t word_in,
	output logic busy,
	output logic done,
	output bch_pkg::word_t word_out,
	output logic [1:0] err_count,
	output logic fail
);

	bch_pkg::syn_t syn;	// syndromes to the locator.
	bch_pkg::sigma_t sigma;	// locator to the search.
	bch_pkg::word_t word_held;	// received word for correction.
	logic syn_start;
	logic loc_start;
	logic chien_start;

	bch_sequencer u_sequencer (
		.clk(clk),
		.rst_n(rst_n),
		.start(start),
		.busy(busy),
		.syn_start(syn_start),
		.loc_start(loc_start),
		.chien_start(chien_start),
		.done(done)
	);

	bch_syndrome u_syndrome (
		.clk(clk),
		.rst_n(rst_n),
		.syn_start(syn_start),
		.word_in(word_in),
		.syn(syn),
		.word_held(word_held)
	);

	bch_locator u_locator (
		.clk(clk),
		.rst_n(rst_n),
		.loc_start(loc_start),
		.syn(syn),
		.sigma(sigma)
	);

	bch_chien u_chien (
		.clk(clk),
		.rst_n(rst_n),
		.chien_start(chien_start),
		.sigma(sigma),
		.word_held(word_held),
		.word_out(word_out),
		.err_count(err_count),
		.fail(fail)
	);

endmodule

`default_nettype wire

// ==== bench/bch_decoder_check.sv ====
`timescale 1ns/10ps
`default_nettype none

module bch_decoder_check (
	input wire clk,
	input wire rst_n,
	input wire start,
	input wire busy,
	input wire done,
	input wire bch_pkg::word_t word_in,
	input wire bch_pkg::word_t word_out,
	input wire [1:0] err_count,
	input wire fail,
	input wire bch_pkg::word_t exp_code,
	input wire [2:0] exp_nerr,
	output int errors,
	output int checked
);

	localparam logic [10:0] gen_poly = 11'h537;	// generator of the (15,5) code.

	bch_pkg::word_t rx_q;	// received word at accept.
	bch_pkg::word_t code_q;	// codeword before the flips.
	logic [2:0] nerr_q;
	logic pending;	// decode in flight.
	logic done_q;
	int cyc;	// edges since reset.
	int acc_cyc;
	int err_n = 0;
	int chk_n = 0;

	assign errors = err_n;
	assign checked = chk_n;

	// long division over gf(2), zero for a codeword.
	function automatic logic [9:0] poly_remainder(input bch_pkg::word_t w);
		bch_pkg::word_t r;
		r = w;
		for (int i = bch_pkg::bch_n - 1; i >= 10; i--) begin
			if (r[i])
				r ^= bch_pkg::word_t'(gen_poly) << (i - 10);
		end
		return r[9:0];
	endfunction

	task automatic fault(input string what);
		err_n++;
		$display("%0t: %s", $time, what);
	endtask

	task automatic compare_hex(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			err_n++;
			$display("Mismatch %s: got 0x%0h expected 0x%0h", name, got, exp);
		end
	endtask

	task automatic check_result();
		chk_n++;
		if (nerr_q <= 3'd3) begin
			compare_hex("word_out", 32'(word_out), 32'(code_q));
			compare_hex("err_count", 32'(err_count), 32'(nerr_q));
			compare_hex("fail", 32'(fail), 32'h0);
		end else if (fail) begin
			compare_hex("word_out", 32'(word_out), 32'(rx_q));	// left uncorrected.
		end else begin
			if (poly_remainder(word_out) != '0)
				fault("four errors corrected to a word that is not a codeword");
			if ($countones(word_out ^ rx_q) != 3)
				fault("four errors corrected to a codeword not at distance three");
		end
	endtask

	always @(posedge clk) begin : watch
		if (!rst_n) begin
			pending <= 1'b0;
			done_q <= 1'b0;
			cyc <= 0;
			acc_cyc <= 0;
			if (busy !== 1'b0 || done !== 1'b0)
				fault("busy or done high while in reset");
		end else begin
			cyc <= cyc + 1;
			done_q <= done;
			if (done && done_q)
				fault("done held high for more than one cycle");
			if (pending && !busy && cyc - acc_cyc <= bch_pkg::bch_lat)
				fault("busy dropped before the decode finished");
			if (done) begin
				if (!pending) begin
					fault("done without an accepted start");
				end else begin
					// done is seen one edge after it rises.
					compare_hex("done_latency", 32'(cyc - acc_cyc),
						32'(bch_pkg::bch_lat + 1));
					check_result();
				end
				pending <= 1'b0;
			end
			if (start && !busy) begin
				if (pending)
					fault("start accepted while a decode was in flight");
				pending <= 1'b1;
				acc_cyc <= cyc;
				rx_q <= word_in;
				code_q <= exp_code;
				nerr_q <= exp_nerr;
			end
		end
	end

endmodule

`default_nettype wire

// ==== bench/bch_decoder_props.sv ====
`timescale 1ns/10ps
`default_nettype none

module bch_decoder_props (
	input wire clk,
	input wire rst_n,
	input wire start,
	input wire busy,
	input wire done
);

	logic accept;

	assign accept = start && !busy;	// same rule as the sequencer.

	latency_a: assert property (@(posedge clk) disable iff (!rst_n)
		accept |=> ##(bch_pkg::bch_lat) done)
		else $error("done missed its slot after an accepted start");

	pulse_a: assert property (@(posedge clk) disable iff (!rst_n)
		done |=> !done)
		else $error("done longer than one cycle");

	idle_a: assert property (@(posedge clk) disable iff (!rst_n)
		done |-> !busy)
		else $error("busy still high with done");

	hold_a: assert property (@(posedge clk) disable iff (!rst_n)
		$fell(busy) |-> done)
		else $error("busy fell without done");

	rise_a: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(busy) |-> $past(start))
		else $error("busy rose without a start");

	// busy and done stay low for the whole reset.
	reset_a: assert property (@(posedge clk)
		!rst_n |-> (!busy && !done))
		else $error("busy or done high in reset");

endmodule

bind bch_decoder bch_decoder_props u_props (
	.clk(clk),
	.rst_n(rst_n),
	.start(start),
	.busy(busy),
	.done(done)
);

`default_nettype wire

// ==== bench/bch_decoder_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module bch_decoder_tb;

	localparam int clk_period = 100;
	localparam int n_rows = 24;
	localparam int n_fixed = 12;
	localparam logic [10:0] gen_poly = 11'h537;	// x^10+x^8+x^5+x^4+x^2+x+1.
	localparam int limit_cycles = 16 + n_rows * (bch_pkg::bch_lat + 4) + 100;

	typedef struct packed {
		logic [4:0] msg;
		bch_pkg::word_t mask;	// error bits to flip.
		bch_pkg::word_t code;	// expected word_out.
		logic [2:0] nerr;	// expected err_count, 4 means beyond t.
	} row_t;

	// edge positions 0 and 14, zero to four errors.
	localparam logic [4:0] fixed_msg [n_fixed] = '{
		5'h00, 5'h1f, 5'h15, 5'h0a, 5'h13, 5'h07,
		5'h19, 5'h1c, 5'h0e, 5'h01, 5'h1e, 5'h11
	};
	localparam bch_pkg::word_t fixed_mask [n_fixed] = '{
		15'h0000, 15'h0000, 15'h0001, 15'h4000, 15'h4001, 15'h4003,
		15'h6001, 15'h000f, 15'h7800, 15'h4101, 15'h0801, 15'h6003
	};

	logic clk;
	logic rst_n;
	logic start;
	bch_pkg::word_t word_in;
	logic busy;
	logic done;
	bch_pkg::word_t word_out;
	logic [1:0] err_count;
	logic fail;
	bch_pkg::word_t exp_code;
	logic [2:0] exp_nerr;
	int errors;
	int checked;
	row_t rows [n_rows];

	bch_decoder u_bch_decoder (
		.clk(clk),
		.rst_n(rst_n),
		.start(start),
		.word_in(word_in),
		.busy(busy),
		.done(done),
		.word_out(word_out),
		.err_count(err_count),
		.fail(fail)
	);

	bch_decoder_check u_check (
		.clk(clk),
		.rst_n(rst_n),
		.start(start),
		.busy(busy),
		.done(done),
		.word_in(word_in),
		.word_out(word_out),
		.err_count(err_count),
		.fail(fail),
		.exp_code(exp_code),
		.exp_nerr(exp_nerr),
		.errors(errors),
		.checked(checked)
	);

	// message times g(x), non-systematic.
	function automatic bch_pkg::word_t encode_message(input logic [4:0] msg);
		bch_pkg::word_t code;
		code = '0;
		for (int i = 0; i < bch_pkg::bch_k; i++) begin
			if (msg[i])
				code ^= bch_pkg::word_t'(gen_poly) << i;
		end
		return code;
	endfunction

	function automatic bch_pkg::word_t random_mask(input int n);
		bch_pkg::word_t m;
		m = '0;
		while ($countones(m) < n)
			m |= bch_pkg::word_t'(1) << ($urandom % bch_pkg::bch_n);	// distinct bits.
		return m;
	endfunction

	task automatic fill_table();
		for (int i = 0; i < n_rows; i++) begin
			if (i < n_fixed) begin
				rows[i].msg = fixed_msg[i];
				rows[i].mask = fixed_mask[i];
			end else begin
				rows[i].msg = 5'($urandom);
				rows[i].mask = random_mask(int'($urandom % 5));
			end
			rows[i].code = encode_message(rows[i].msg);
			rows[i].nerr = 3'($countones(rows[i].mask));
		end
	endtask

	task automatic decode_row(input row_t row);
		start <= 1'b1;
		word_in <= row.code ^ row.mask;
		exp_code <= row.code;
		exp_nerr <= row.nerr;
		@(posedge clk);
		start <= 1'b0;	// accepted at this edge.
		repeat (3) @(posedge clk);
		start <= 1'b1;	// stray start while busy.
		word_in <= ~(row.code ^ row.mask);
		@(posedge clk);
		start <= 1'b0;
		@(posedge clk);
		while (done !== 1'b1)
			@(posedge clk);
	endtask

	initial begin : clock_gen
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	initial begin : watchdog
		#(limit_cycles * clk_period);
		$display("timeout: decoding did not finish within %0d cycles", limit_cycles);
		$display("Simulation failed");
		$finish;
	end

	initial begin : stimulus
		rst_n <= 1'b0;
		start <= 1'b0;
		word_in <= '0;
		exp_code <= '0;
		exp_nerr <= '0;
		void'($urandom(59157));
		fill_table();
		repeat (16) @(posedge clk);
		rst_n <= 1'b1;
		repeat (2) @(posedge clk);
		for (int i = 0; i < n_rows; i++)
			decode_row(rows[i]);	// next start goes out right after done.
		repeat (4) @(posedge clk);
		$display("decodes checked %0d of %0d, errors %0d", checked, n_rows, errors);
		if (errors == 0 && checked == n_rows)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== build.f ====
verilog/bch_pkg.sv
verilog/bch_syndrome.sv
verilog/bch_locator.sv
verilog/bch_chien.sv
verilog/bch_sequencer.sv
verilog/bch_decoder.sv
bench/bch_decoder_check.sv
bench/bch_decoder_props.sv
bench/bch_decoder_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS = --binary --timing --assert -j 0
TOP = bch_decoder_tb
FILELIST = build.f
OBJ_DIR = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "Simulation passed"

clean:
	rm -rf $(OBJ_DIR)
